// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tftCtrlTb
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== design/spiArbiter.sv ====
// SPI arbiter.
// Shares the byte transmitter between the init sequencer and the pixel streamer,
// init first.
module spiArbiter
    import tftTypesPkg::*;
(
    input  logic    CLK_I,
    input  logic    RST_I,
    input  logic    initReq,
    input  logic    initDc,
    input  logic    pixReq,
    input  logic    pixDc,
    input  spiByteT initByte,
    input  spiByteT pixByte,
    input  logic    txBusy,
    input  logic    txDone,
    output logic    initDone,
    output logic    pixDone,
    output logic    txStart,
    output spiByteT txByte,
    output logic    txDc
);
    logic granted;    // a byte is in flight.
    logic ownerPix;   // owner of that byte.
    logic selPix;

    // before a grant, pick by priority; after it, follow the owner.
    assign selPix  = granted ? ownerPix : !initReq;
    assign txStart = !granted && !txBusy && (initReq || pixReq);
    assign txByte  = selPix ? pixByte : initByte;
    assign txDc    = selPix ? pixDc : initDc;

    assign initDone = txDone && granted && !ownerPix;
    assign pixDone  = txDone && granted && ownerPix;

    always_ff @(posedge CLK_I)
    begin
        if (RST_I)
        begin
            granted  <= 1'b0;
            ownerPix <= 1'b0;
        end
        else if (txStart)
        begin
            granted  <= 1'b1;
            ownerPix <= selPix;
        end
        else if (txDone)
            granted <= 1'b0;
    end

    // transmitter must take every start; a lost start would hang the grant.
    assert property (@(posedge CLK_I) disable iff (RST_I) txStart |=> txBusy);

    // a done only ends a granted byte whose owner still requests it.
    assert property (@(posedge CLK_I) disable iff (RST_I)
        txDone |-> granted && (ownerPix ? pixReq : initReq));

endmodule

// ==== design/spiByteTx.sv ====
// SPI byte transmitter.
// Sends one byte in mode 0, MSB first, with chip select framing each byte.
module spiByteTx
    import tftTypesPkg::*;
    import tftProtocolPkg::*;
(
    input  logic    CLK_I,
    input  logic    RST_I,
    input  logic    start,
    input  spiByteT txByte,
    input  logic    txDc,
    output logic    busy,
    output logic    done,
    output logic    tftCsN,
    output logic    tftSck,
    output logic    tftMosi,
    output logic    tftDc
);
    localparam int tickW = $clog2(sckHalfTicks + 1);

    spiByteT          shiftReg;
    logic [tickW-1:0] tickCnt;
    logic [2:0]       bitCnt;
    logic             halfEnd;

    assign halfEnd = (tickCnt == tickW'(sckHalfTicks - 1));

    always_ff @(posedge CLK_I)
    begin
        if (RST_I)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            tftCsN  <= 1'b1;
            tftSck  <= 1'b0;
            tftDc   <= 1'b0;
            tickCnt <= '0;
            bitCnt  <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (start)
                begin
                    busy    <= 1'b1;
                    tftCsN  <= 1'b0;
                    tftDc   <= txDc;
                    tickCnt <= '0;
                    bitCnt  <= '0;
                end
            end
            else if (halfEnd)
            begin
                tickCnt <= '0;
                tftSck  <= ~tftSck;
                if (tftSck)   // falling SCK closes the bit.
                begin
                    bitCnt <= bitCnt + 3'd1;
                    if (bitCnt == 3'd7)
                    begin
                        busy   <= 1'b0;
                        tftCsN <= 1'b1;
                        done   <= 1'b1;
                    end
                end
            end
            else
                tickCnt <= tickCnt + tickW'(1);
        end
    end

    // shift on the falling SCK so MOSI settles before the next rise.
    always_ff @(posedge CLK_I)
    begin
        if (start && !busy)
            shiftReg <= txByte;
        else if (busy && halfEnd && tftSck)
            shiftReg <= {shiftReg[6:0], 1'b0};
    end

    assign tftMosi = busy & shiftReg[7];   // idle low between bytes.

    // the arbiter only starts an idle transmitter.
    assert property (@(posedge CLK_I) disable iff (RST_I) start |-> !busy);

endmodule

// ==== design/tftCtrl.sv ====
// ILI9341 controller top.
// Init sequencer and pixel streamer share one SPI byte transmitter.
module tftCtrl
    import tftTypesPkg::*;
#(
    parameter int ticksPerMs = 50000,
    parameter int frameCols  = 240,
    parameter int frameRows  = 320
)
(
    input  logic      CLK_I,
    input  logic      RST_I,
    input  logic      frameStart,
    input  logic      pixelReady,
    input  pixelT     pixelData,
    output pixelAddrT pixelAddr,
    output logic      initDone,
    output logic      frameDone,
    output logic      tftCsN,
    output logic      tftSck,
    output logic      tftMosi,
    output logic      tftDc,
    output logic      tftResetN
);
    logic    initReq, initTxDc, initByteDone;
    logic    pixReq, pixTxDc, pixByteDone;
    spiByteT initTxByte, pixTxByte, txByte;
    logic    txStart, txDc, txBusy, txDone;

    tftInitSequencer #(.ticksPerMs(ticksPerMs)) initSeq (
        .CLK_I(CLK_I), .RST_I(RST_I),
        .byteDone(initByteDone),
        .tftResetN(tftResetN),
        .byteReq(initReq), .txByte(initTxByte), .txDc(initTxDc),
        .initDone(initDone)
    );

    tftPixelStreamer #(.frameCols(frameCols), .frameRows(frameRows)) pixStream (
        .CLK_I(CLK_I), .RST_I(RST_I),
        .initDone(initDone), .frameStart(frameStart), .pixelReady(pixelReady),
        .pixelData(pixelData), .byteDone(pixByteDone),
        .pixelAddr(pixelAddr),
        .byteReq(pixReq), .txByte(pixTxByte), .txDc(pixTxDc),
        .frameDone(frameDone)
    );

    spiArbiter arb (
        .CLK_I(CLK_I), .RST_I(RST_I),
        .initReq(initReq), .initDc(initTxDc), .initByte(initTxByte),
        .pixReq(pixReq), .pixDc(pixTxDc), .pixByte(pixTxByte),
        .txBusy(txBusy), .txDone(txDone),
        .initDone(initByteDone), .pixDone(pixByteDone),
        .txStart(txStart), .txByte(txByte), .txDc(txDc)
    );

    spiByteTx spiTx (
        .CLK_I(CLK_I), .RST_I(RST_I),
        .start(txStart), .txByte(txByte), .txDc(txDc),
        .busy(txBusy), .done(txDone),
        .tftCsN(tftCsN), .tftSck(tftSck), .tftMosi(tftMosi), .tftDc(tftDc)
    );

endmodule

// ==== design/tftInitSequencer.sv ====
// Panel init sequencer.
// Pulses the panel reset, waits for wake-up, then sends the init table.
module tftInitSequencer
    import tftTypesPkg::*;
    import tftProtocolPkg::*;
#(
    parameter int ticksPerMs = 50000
)
(
    input  logic    CLK_I,
    input  logic    RST_I,
    input  logic    byteDone,
    output logic    tftResetN,
    output logic    byteReq,
    output spiByteT txByte,
    output logic    txDc,
    output logic    initDone
);
    `include "tftInitTable.svh"

    localparam int holdTicks = resetHoldMs * ticksPerMs;
    localparam int wakeTicks = wakeMs * ticksPerMs;
    localparam int maxTicks  = (holdTicks > wakeTicks) ? holdTicks : wakeTicks;
    localparam int delayW    = $clog2(maxTicks + 1);
    localparam int idxW      = $clog2(initTableLen);

    typedef enum logic [2:0] {
        stResetHold,
        stResetWait,
        stSend,
        stFinalWait,
        stDone
    } initStateT;

    initStateT         state;
    logic [delayW-1:0] delayCnt;
    logic [idxW-1:0]   tableIdx;
    logic              delayZero;
    cmdEntryT          entry;

    assign delayZero = (delayCnt == '0);
    assign entry     = initTable[tableIdx];
    assign txByte    = entry[7:0];
    assign txDc      = entry[8];
    assign byteReq   = (state == stSend);
    assign initDone  = (state == stDone);

    always_ff @(posedge CLK_I)
    begin
        if (RST_I)
        begin
            state     <= stResetHold;
            delayCnt  <= delayW'(holdTicks);
            tableIdx  <= '0;
            tftResetN <= 1'b1;   // panel reset released while we are in reset.
        end
        else
        begin
            case (state)
                stResetHold:
                begin
                    if (delayZero)
                    begin
                        tftResetN <= 1'b1;
                        delayCnt  <= delayW'(wakeTicks);
                        state     <= stResetWait;
                    end
                    else
                    begin
                        tftResetN <= 1'b0;
                        delayCnt  <= delayCnt - delayW'(1);
                    end
                end
                stResetWait:
                begin
                    if (delayZero)
                        state <= stSend;
                    else
                        delayCnt <= delayCnt - delayW'(1);
                end
                stSend:
                begin
                    if (byteDone && tableIdx == idxW'(initTableLen - 1))
                    begin
                        delayCnt <= delayW'(wakeTicks);
                        state    <= stFinalWait;
                    end
                    else if (byteDone)
                        tableIdx <= tableIdx + idxW'(1);
                end
                stFinalWait:
                begin
                    if (delayZero)
                        state <= stDone;
                    else
                        delayCnt <= delayCnt - delayW'(1);
                end
                default: ;   // done, stays here until reset.
            endcase
        end
    end

endmodule

// ==== design/tftPixelStreamer.sv ====
// Pixel streamer.
// Sets the full-frame window, then sends every pixel high byte first,
// once per accepted frame start.
module tftPixelStreamer
    import tftTypesPkg::*;
    import tftProtocolPkg::*;
#(
    parameter int frameCols = 240,
    parameter int frameRows = 320
)
(
    input  logic      CLK_I,
    input  logic      RST_I,
    input  logic      initDone,
    input  logic      frameStart,
    input  logic      pixelReady,
    input  pixelT     pixelData,
    input  logic      byteDone,
    output pixelAddrT pixelAddr,
    output logic      byteReq,
    output spiByteT   txByte,
    output logic      txDc,
    output logic      frameDone
);
    localparam int          pixCount = frameCols * frameRows;
    localparam pixelAddrT   lastAddr = pixelAddrT'(pixCount - 1);
    localparam logic [15:0] lastCol  = 16'(frameCols - 1);
    localparam logic [15:0] lastRow  = 16'(frameRows - 1);

    typedef enum logic [2:0] {
        stIdle,
        stWindow,
        stMemWrite,
        stPixWait,
        stHigh,
        stLow
    } streamStateT;

    streamStateT state;
    logic [3:0]  step;       // window byte index, 0 to 9.
    pixelT       pixLatch;
    spiByteT     windowByte;
    logic        windowDc;

    // column set at step 0, page set at step 5, start addresses are zero.
    always_comb
    begin
        case (step)
            4'd0:    windowByte = cmdColumnSet;
            4'd3:    windowByte = lastCol[15:8];
            4'd4:    windowByte = lastCol[7:0];
            4'd5:    windowByte = cmdPageSet;
            4'd8:    windowByte = lastRow[15:8];
            4'd9:    windowByte = lastRow[7:0];
            default: windowByte = 8'h00;
        endcase
    end

    assign windowDc = (step != 4'd0) && (step != 4'd5);

    always_comb
    begin
        case (state)
            stWindow:   txByte = windowByte;
            stMemWrite: txByte = cmdMemWrite;
            stLow:      txByte = pixLatch[7:0];
            default:    txByte = pixLatch[15:8];
        endcase
    end

    assign txDc    = (state == stWindow) ? windowDc : (state != stMemWrite);
    assign byteReq = state inside {stWindow, stMemWrite, stHigh, stLow};

    always_ff @(posedge CLK_I)
    begin
        if (RST_I)
        begin
            state     <= stIdle;
            step      <= '0;
            pixelAddr <= '0;
            frameDone <= 1'b0;
        end
        else
        begin
            frameDone <= 1'b0;
            case (state)
                stIdle:
                begin
                    step <= '0;
                    if (frameStart && initDone)
                        state <= stWindow;
                end
                stWindow:
                begin
                    if (byteDone && step == 4'd9)
                        state <= stMemWrite;
                    else if (byteDone)
                        step <= step + 4'd1;
                end
                stMemWrite: if (byteDone) state <= stPixWait;
                stPixWait:  if (pixelReady) state <= stHigh;
                stHigh:     if (byteDone) state <= stLow;
                stLow:
                begin
                    if (byteDone && pixelAddr == lastAddr)
                    begin
                        pixelAddr <= '0;
                        frameDone <= 1'b1;
                        state     <= stIdle;
                    end
                    else if (byteDone)
                    begin
                        pixelAddr <= pixelAddr + pixelAddrT'(1);
                        state     <= stPixWait;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // pixel sampled once, so both bytes come from the same value.
    always_ff @(posedge CLK_I)
    begin
        if (state == stPixWait && pixelReady)
            pixLatch <= pixelData;
    end

    assert property (@(posedge CLK_I) disable iff (RST_I)
        pixelAddr < pixelAddrT'(pixCount));

endmodule

// ==== design/tftProtocolPkg.sv ====
// ILI9341 protocol constants.
// Window and memory write opcodes, SPI clock divide and power-up delays.
package tftProtocolPkg;
    import tftTypesPkg::*;

    // window setup and pixel write opcodes.
    localparam spiByteT cmdColumnSet = 8'h2A;
    localparam spiByteT cmdPageSet   = 8'h2B;
    localparam spiByteT cmdMemWrite  = 8'h2C;

    // clock cycles per SCK half period.
    localparam int sckHalfTicks = 2;

    // panel reset pulse width in ms.
    localparam int resetHoldMs = 10;

    // wait after reset release, and again after the init table.
    localparam int wakeMs = 120;

endpackage

// ==== design/tftTypesPkg.sv ====
// TFT controller types.
// Vector widths shared by the SPI path, the init table and the pixel stream.
package tftTypesPkg;

    // one byte on the SPI bus.
    typedef logic [7:0] spiByteT;

    // one RGB565 pixel.
    typedef logic [15:0] pixelT;

    // pixel index, wide enough for 320 x 240.
    typedef logic [16:0] pixelAddrT;

    // init table entry.
    // bit 8 set means data, clear means command; low byte is the value.
    typedef logic [8:0] cmdEntryT;

endpackage

// ==== include/tftInitTable.svh ====
// ILI9341 init command table.
// Sent once after the power-up wait, one entry per SPI byte.

localparam int initTableLen = 9;

// bit 8 is the data flag.
localparam tftTypesPkg::cmdEntryT initTable [0:initTableLen-1] = '{
    9'h001,   // software reset.
    9'h011,   // sleep out.
    9'h03A,   // pixel format.
    9'h155,   // 16 bits per pixel.
    9'h036,   // memory access control.
    9'h148,   // BGR order, column flip.
    9'h013,   // normal mode.
    9'h029,   // display on.
    9'h000    // no operation.
};

// ==== sim.f ====
+incdir+include
design/tftTypesPkg.sv
design/tftProtocolPkg.sv
design/spiByteTx.sv
design/spiArbiter.sv
design/tftInitSequencer.sv
design/tftPixelStreamer.sv
design/tftCtrl.sv
tests/tftCtrlTb.sv

// ==== tests/tftCtrlTb.sv ====
// TFT controller testbench.
// Runs the panel init and two frames, decodes the SPI bytes and checks
// them against the expected stream with concurrent assertions.
module tftCtrlTb
    import tftTypesPkg::*;
    import tftProtocolPkg::*;
();
    `include "tftInitTable.svh"

    localparam int clkPeriod      = 100;
    localparam int tbTicks        = 4;
    localparam int tbCols         = 8;
    localparam int tbRows         = 4;
    localparam int pixCount       = tbCols * tbRows;
    localparam int windowLen      = 11;   // column set, page set, memory write.
    localparam int frameLen       = windowLen + 2 * pixCount;
    localparam int totalBytes     = initTableLen + 2 * frameLen;
    localparam int holdCycles     = resetHoldMs * tbTicks;
    localparam int wakeCycles     = wakeMs * tbTicks;
    localparam int byteCycles     = 16 * sckHalfTicks + 4;   // byte plus arbiter gap.
    localparam int watchdogCycles =
        2 * (10 + holdCycles + 2 * wakeCycles + totalBytes * byteCycles);
    localparam int unsigned randSeed = 32'hc51a8622;

    logic      CLK_I = 1'b0;
    logic      RST_I;
    logic      frameStart;
    logic      pixelReady;
    pixelT     pixelData = '0;
    pixelAddrT pixelAddr;
    logic      initDone, frameDone;
    logic      tftCsN, tftSck, tftMosi, tftDc, tftResetN;

    logic      sckPrev, csPrev, dcIn, rxValid, readySeen, frameBusy;
    spiByteT   shiftIn;
    cmdEntryT  rxWord, expWord;
    int        rxIdx, byteCount, framesSeen, framesAccepted, lowCycles, relCycles;
    logic      nextIsPixel, nextIsHigh;
    pixelAddrT nextAddr;

    tftCtrl #(.ticksPerMs(tbTicks), .frameCols(tbCols), .frameRows(tbRows)) UUT (
        .CLK_I(CLK_I), .RST_I(RST_I),
        .frameStart(frameStart), .pixelReady(pixelReady), .pixelData(pixelData),
        .pixelAddr(pixelAddr), .initDone(initDone), .frameDone(frameDone),
        .tftCsN(tftCsN), .tftSck(tftSck), .tftMosi(tftMosi), .tftDc(tftDc),
        .tftResetN(tftResetN)
    );

    // pixel source rule, any fixed mix of the address bits.
    function automatic pixelT pixelFor(pixelAddrT addr);
        return {addr[7:0] ^ 8'h5A, addr[7:0] * 8'd3 + 8'h11};
    endfunction

    // offset of a byte inside its frame, -1 while in the init table.
    function automatic int framePos(int idx);
        if (idx < initTableLen)
            return -1;
        return (idx - initTableLen) % frameLen;
    endfunction

    // expected {dc, byte} for stream position idx.
    function automatic cmdEntryT expectedWord(int idx);
        int          pos;
        pixelT       px;
        logic [15:0] lastCol;
        logic [15:0] lastRow;
        cmdEntryT    word;
        pos     = framePos(idx);
        lastCol = 16'(tbCols - 1);
        lastRow = 16'(tbRows - 1);
        px      = pixelFor(pixelAddrT'((pos - windowLen) / 2));
        case (pos)
            -1:         word = initTable[4'(idx)];
            0:          word = {1'b0, cmdColumnSet};
            1, 2, 6, 7: word = {1'b1, 8'h00};   // window starts at zero.
            3:          word = {1'b1, lastCol[15:8]};
            4:          word = {1'b1, lastCol[7:0]};
            5:          word = {1'b0, cmdPageSet};
            8:          word = {1'b1, lastRow[15:8]};
            9:          word = {1'b1, lastRow[7:0]};
            10:         word = {1'b0, cmdMemWrite};
            default:    word = ((pos - windowLen) % 2 == 0) ? {1'b1, px[15:8]}
                                                            : {1'b1, px[7:0]};
        endcase
        return word;
    endfunction

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic pulseFrameStart();
        @(negedge CLK_I);
        frameStart = 1'b1;
        @(negedge CLK_I);
        frameStart = 1'b0;
    endtask

    assign expWord     = expectedWord(rxIdx);
    assign nextIsPixel = framePos(byteCount) >= windowLen;
    assign nextIsHigh  = nextIsPixel && ((framePos(byteCount) - windowLen) % 2 == 0);
    assign nextAddr    = pixelAddrT'((framePos(byteCount) - windowLen) / 2);

    always #(clkPeriod / 2) CLK_I = ~CLK_I;

    always @(negedge CLK_I)
        pixelData <= pixelFor(pixelAddr);   // answers in the same cycle.

    // SPI decoder, sampled on the system clock.
    always @(posedge CLK_I)
    begin
        if (RST_I)
        begin
            sckPrev   <= 1'b0;
            csPrev    <= 1'b1;
            shiftIn   <= '0;
            dcIn      <= 1'b0;
            rxWord    <= '0;
            rxValid   <= 1'b0;
            rxIdx     <= 0;
            byteCount <= 0;
            readySeen <= 1'b0;
        end
        else
        begin
            sckPrev <= tftSck;
            csPrev  <= tftCsN;
            rxValid <= 1'b0;
            if (tftSck && !sckPrev && !tftCsN)   // rising SCK.
            begin
                shiftIn <= {shiftIn[6:0], tftMosi};
                dcIn    <= tftDc;
            end
            if (tftCsN && !csPrev)
            begin
                rxWord    <= {dcIn, shiftIn};
                rxIdx     <= byteCount;
                byteCount <= byteCount + 1;
                rxValid   <= 1'b1;
                readySeen <= 1'b0;
            end
            else if (pixelReady)
                readySeen <= 1'b1;
        end
    end

    // reset timing and frame bookkeeping.
    always @(posedge CLK_I)
    begin
        if (RST_I)
        begin
            lowCycles      <= 0;
            relCycles      <= 0;
            framesSeen     <= 0;
            framesAccepted <= 0;
            frameBusy      <= 1'b0;
        end
        else
        begin
            if (!tftResetN)
                lowCycles <= lowCycles + 1;
            relCycles <= tftResetN ? relCycles + 1 : 0;
            if (frameStart && initDone && !frameBusy)
            begin
                framesAccepted <= framesAccepted + 1;
                frameBusy      <= 1'b1;
            end
            else if (frameDone)
                frameBusy <= 1'b0;
            if (frameDone)
                framesSeen <= framesSeen + 1;
        end
    end

    resetOutputs: assert property (@(posedge CLK_I) RST_I |=> (tftCsN && !tftSck
        && !initDone && !frameDone && pixelAddr == '0 && tftResetN))
    else
    begin
        $display("Error: tftCsN=%h tftSck=%h initDone=%h frameDone=%h pixelAddr=%h tftResetN=%h",
            tftCsN, tftSck, initDone, frameDone, pixelAddr, tftResetN);
        abortRun();
    end

    resetStart: assert property (@(posedge CLK_I) $fell(RST_I) |=> !tftResetN)
    else
    begin
        $display("Error: tftResetN=%h after reset release, expected 0", tftResetN);
        abortRun();
    end

    resetWidth: assert property (@(posedge CLK_I) disable iff (RST_I)
        $rose(tftResetN) |-> lowCycles == holdCycles)
    else
    begin
        $display("Error: tftResetN low for %h cycles, expected %h", lowCycles, holdCycles);
        abortRun();
    end

    resetOnce: assert property (@(posedge CLK_I) disable iff (RST_I)
        $fell(tftResetN) |-> lowCycles == 0)
    else
    begin
        $display("Panel reset was pulsed low a second time.");
        abortRun();
    end

    wakeQuiet: assert property (@(posedge CLK_I) disable iff (RST_I)
        !tftCsN |-> relCycles >= wakeCycles)
    else
    begin
        $display("Error: tftCsN low %h cycles after reset release, expected at least %h",
            relCycles, wakeCycles);
        abortRun();
    end

    byteAllowed: assert property (@(posedge CLK_I) disable iff (RST_I)
        rxValid |-> rxIdx < initTableLen + frameLen * framesAccepted)
    else
    begin
        $display("SPI byte %0d was sent outside the init table and accepted frames.", rxIdx);
        abortRun();
    end

    byteValue: assert property (@(posedge CLK_I) disable iff (RST_I)
        rxValid |-> rxWord == expWord)
    else
    begin
        $display("Error: SPI byte %0d {tftDc,tftMosi} = %h, expected %h", rxIdx, rxWord, expWord);
        abortRun();
    end

    initAfterTable: assert property (@(posedge CLK_I) disable iff (RST_I)
        $rose(initDone) |-> byteCount == initTableLen)
    else
    begin
        $display("Error: initDone rose after %h bytes, expected %h", byteCount, initTableLen);
        abortRun();
    end

    readyBeforeHigh: assert property (@(posedge CLK_I) disable iff (RST_I)
        $fell(tftCsN) && nextIsHigh |-> readySeen)
    else
    begin
        $display("A pixel high byte started while pixelReady was low.");
        abortRun();
    end

    addrHeld: assert property (@(posedge CLK_I) disable iff (RST_I)
        $fell(tftCsN) && nextIsPixel |-> pixelAddr == nextAddr)
    else
    begin
        $display("Error: pixelAddr = %h at byte start, expected %h", pixelAddr, nextAddr);
        abortRun();
    end

    frameCount: assert property (@(posedge CLK_I) disable iff (RST_I)
        frameDone |-> byteCount == initTableLen + frameLen * framesAccepted)
    else
    begin
        $display("Error: frameDone after %h bytes, expected %h", byteCount,
            initTableLen + frameLen * framesAccepted);
        abortRun();
    end

    frameAddr: assert property (@(posedge CLK_I) disable iff (RST_I)
        frameDone |-> pixelAddr == '0)
    else
    begin
        $display("Error: pixelAddr = %h at frameDone, expected 0", pixelAddr);
        abortRun();
    end

    framePulse: assert property (@(posedge CLK_I) disable iff (RST_I) frameDone |=> !frameDone)
    else
    begin
        $display("frameDone stayed high for more than one cycle.");
        abortRun();
    end

    initial
    begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles.", watchdogCycles);
        abortRun();
    end

    initial
    begin
        int f;
        RST_I      = 1'b1;
        frameStart = 1'b0;
        pixelReady = 1'b0;
        void'($urandom(randSeed));
        repeat (10) @(negedge CLK_I);
        RST_I = 1'b0;
        pulseFrameStart();   // panel still in reset, must be ignored.
        while (tftCsN)
            @(negedge CLK_I);
        pulseFrameStart();   // table in flight, also ignored.
        while (!initDone)
            @(negedge CLK_I);
        for (f = 0; f < 2; f++)
        begin
            pulseFrameStart();
            while (framesSeen == f)
            begin
                @(negedge CLK_I);
                pixelReady = ($urandom % 4) != 0;   // stall about one pixel in four.
            end
            pixelReady = 1'b0;
        end
        repeat (5) @(negedge CLK_I);
        if (byteCount != totalBytes || framesSeen != 2 || !initDone)
        begin
            $display("Error: byteCount = %h framesSeen = %h, expected %h and 2",
                byteCount, framesSeen, totalBytes);
            abortRun();
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
